//--- common/periph_pkg.sv
package periph_pkg;

  // Widths that carry a meaning on the peripheral bus
  typedef logic [31:0] word_t;
  typedef logic [3:0]  byte_en_t;
  typedef logic [15:0] half_period_t;

  // What the bus master drives every cycle
  typedef struct packed {
    word_t    addr;
    word_t    wdata;
    byte_en_t wenable;
  } bus_req_t;

  typedef enum logic [2:0] {
    SEL_RAM,
    SEL_NOISE,
    SEL_JOYPAD,
    SEL_LCD,
    SEL_AUDIO,
    SEL_NONE
  } periph_sel_e;

  // Upper three bits of addr[31:28]; the low nibble bit is a don't care
  localparam logic [2:0] REGION_RAM    = 3'b000;
  localparam logic [2:0] REGION_NOISE  = 3'b001;
  localparam logic [2:0] REGION_JOYPAD = 3'b011;
  localparam logic [2:0] REGION_LCD    = 3'b110;
  localparam logic [2:0] REGION_AUDIO  = 3'b111;

  // Video and spare codes (0100, 0101, 100x, 101x) fall through to SEL_NONE

endpackage

//--- source/periph_bus_decode.sv
`timescale 1ns/100ps

module periph_bus_decode (
  input  logic                   clk,
  input  logic                   rst_n,
  input  periph_pkg::bus_req_t   bus,
  input  logic [4:0]             joypad,
  input  periph_pkg::word_t      ram_rdata,
  input  periph_pkg::word_t      noise_rdata,
  input  logic [8:0]             lcd_status,
  input  periph_pkg::word_t      audio_rdata,
  output periph_pkg::byte_en_t   ram_wenable,
  output logic                   lcd_wstrobe,
  output logic                   audio_wstrobe,
  output periph_pkg::word_t      rdata
);

  periph_pkg::periph_sel_e sel;
  periph_pkg::periph_sel_e sel_q;
  logic [4:0] joy_meta;
  logic [4:0] joy_sync;

  always_comb begin
    case (bus.addr[31:29])
      periph_pkg::REGION_RAM:    sel = periph_pkg::SEL_RAM;
      periph_pkg::REGION_NOISE:  sel = periph_pkg::SEL_NOISE;
      periph_pkg::REGION_JOYPAD: sel = periph_pkg::SEL_JOYPAD;
      periph_pkg::REGION_LCD:    sel = periph_pkg::SEL_LCD;
      periph_pkg::REGION_AUDIO:  sel = periph_pkg::SEL_AUDIO;
      default:                   sel = periph_pkg::SEL_NONE;
    endcase
  end

  // Only the addressed peripheral sees a write
  assign ram_wenable   = (sel == periph_pkg::SEL_RAM) ? bus.wenable : '0;
  assign lcd_wstrobe   = bus.wenable[0] && (sel == periph_pkg::SEL_LCD);
  assign audio_wstrobe = bus.wenable[0] && (sel == periph_pkg::SEL_AUDIO);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sel_q    <= periph_pkg::SEL_NONE;
      joy_meta <= '0;
      joy_sync <= '0;
    end else begin
      sel_q    <= sel;
      joy_meta <= joypad;
      joy_sync <= joy_meta;
    end
  end

  // Every source is a register, so the mux lines up with the RAM read
  always_comb begin
    case (sel_q)
      periph_pkg::SEL_RAM:    rdata = ram_rdata;
      periph_pkg::SEL_NOISE:  rdata = noise_rdata;
      periph_pkg::SEL_JOYPAD: rdata = {27'b0, joy_sync};
      periph_pkg::SEL_LCD:    rdata = {23'b0, lcd_status};
      periph_pkg::SEL_AUDIO:  rdata = audio_rdata;
      default:                rdata = '0;
    endcase
  end

endmodule

//--- source/word_ram.sv
`timescale 1ns/100ps

module word_ram #(
  parameter int RAM_ADDR_BITS = 12
) (
  input  logic                     clk,
  input  logic [RAM_ADDR_BITS-1:0] addr,
  input  periph_pkg::word_t        wdata,
  input  periph_pkg::byte_en_t     wenable,
  output periph_pkg::word_t        rdata
);

  localparam int DEPTH = 2 ** RAM_ADDR_BITS;

  periph_pkg::word_t mem [DEPTH];

  // Read before write on the same address
  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (wenable[i]) begin
        mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
      end
    end
    rdata <= mem[addr];
  end

endmodule

//--- source/noise_lfsr.sv
`timescale 1ns/100ps

module noise_lfsr (
  input  logic              clk,
  input  logic              rst_n,
  output periph_pkg::word_t value
);

  // x^32 + x^22 + x^2 + x + 1, shifted right
  localparam periph_pkg::word_t TAPS = 32'h8020_0003;
  localparam periph_pkg::word_t SEED = 32'h0000_0001;

  periph_pkg::word_t state;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= SEED;
    end else if (state[0]) begin
      state <= (state >> 1) ^ TAPS;
    end else begin
      state <= state >> 1;
    end
  end

  assign value = state;

endmodule

//--- lcd/lcd_unit.sv
`timescale 1ns/100ps

module lcd_unit #(
  parameter int LCD_PULSE_CYCLES = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       wstrobe,
  input  logic       rs,
  input  logic [7:0] wdata,
  output logic [7:0] lcd_data,
  output logic [1:0] lcd_ctrl,
  output logic       lcd_enable,
  output logic       busy
);

  localparam int CNT_BITS = (LCD_PULSE_CYCLES > 1) ? $clog2(LCD_PULSE_CYCLES) : 1;

  typedef enum logic {
    LCD_IDLE,
    LCD_PULSE
  } lcd_state_e;

  lcd_state_e          state;
  logic [CNT_BITS-1:0] pulse_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= LCD_IDLE;
      pulse_cnt <= '0;
      lcd_data  <= '0;
      lcd_ctrl  <= '0;
    end else begin
      case (state)
        LCD_IDLE: begin
          if (wstrobe) begin
            state     <= LCD_PULSE;
            pulse_cnt <= CNT_BITS'(LCD_PULSE_CYCLES - 1);
            lcd_data  <= wdata;
            // Always a write, so R/W stays low
            lcd_ctrl  <= {1'b0, rs};
          end
        end
        LCD_PULSE: begin
          // Writes arriving here are dropped
          if (pulse_cnt == '0) begin
            state <= LCD_IDLE;
          end else begin
            pulse_cnt <= pulse_cnt - 1'b1;
          end
        end
        default: state <= LCD_IDLE;
      endcase
    end
  end

  assign lcd_enable = (state == LCD_PULSE);
  assign busy       = (state == LCD_PULSE);

endmodule

//--- audio/audio_regs.sv
`timescale 1ns/100ps

module audio_regs (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     wstrobe,
  input  periph_pkg::word_t        wdata,
  output periph_pkg::half_period_t half_period,
  output logic                     tone_enable,
  output periph_pkg::word_t        rdata,
  output logic                     restart
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      half_period <= '0;
      tone_enable <= 1'b0;
      restart     <= 1'b0;
    end else begin
      restart <= wstrobe;
      if (wstrobe) begin
        half_period <= wdata[15:0];
        tone_enable <= wdata[16];
      end
    end
  end

  // Bit 16 enable, low half the period
  assign rdata = {15'b0, tone_enable, half_period};

endmodule

//--- audio/audio_tone.sv
`timescale 1ns/100ps

module audio_tone (
  input  logic                     clk,
  input  logic                     rst_n,
  input  periph_pkg::half_period_t half_period,
  input  logic                     tone_enable,
  input  logic                     restart,
  output logic                     audio_out
);

  periph_pkg::half_period_t count;

  // Counts 0 to half_period, so one level lasts half_period + 1 clocks
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count     <= '0;
      audio_out <= 1'b0;
    end else if (restart || !tone_enable) begin
      count     <= '0;
      audio_out <= 1'b0;
    end else if (count == half_period) begin
      count     <= '0;
      audio_out <= ~audio_out;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

//--- source/periph_top.sv
`timescale 1ns/100ps

module periph_top #(
  parameter int RAM_ADDR_BITS    = 12,
  parameter int LCD_PULSE_CYCLES = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  periph_pkg::bus_req_t bus,
  output periph_pkg::word_t    rdata,
  input  logic [4:0]           joypad,
  output logic [7:0]           lcd_data,
  output logic [1:0]           lcd_ctrl,
  output logic                 lcd_enable,
  output logic                 audio_out
);

  periph_pkg::byte_en_t     ram_wenable;
  periph_pkg::word_t        ram_rdata;
  periph_pkg::word_t        noise_rdata;
  periph_pkg::word_t        audio_rdata;
  periph_pkg::half_period_t half_period;
  logic                     lcd_wstrobe;
  logic                     lcd_busy;
  logic                     audio_wstrobe;
  logic                     tone_enable;
  logic                     restart;

  periph_bus_decode decode (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus          (bus),
    .joypad       (joypad),
    .ram_rdata    (ram_rdata),
    .noise_rdata  (noise_rdata),
    .lcd_status   ({lcd_busy, lcd_data}),
    .audio_rdata  (audio_rdata),
    .ram_wenable  (ram_wenable),
    .lcd_wstrobe  (lcd_wstrobe),
    .audio_wstrobe(audio_wstrobe),
    .rdata        (rdata)
  );

  // Word addressed, byte offset bits dropped
  word_ram #(
    .RAM_ADDR_BITS(RAM_ADDR_BITS)
  ) ram (
    .clk    (clk),
    .addr   (bus.addr[RAM_ADDR_BITS+1:2]),
    .wdata  (bus.wdata),
    .wenable(ram_wenable),
    .rdata  (ram_rdata)
  );

  noise_lfsr noise (
    .clk  (clk),
    .rst_n(rst_n),
    .value(noise_rdata)
  );

  lcd_unit #(
    .LCD_PULSE_CYCLES(LCD_PULSE_CYCLES)
  ) lcd (
    .clk       (clk),
    .rst_n     (rst_n),
    .wstrobe   (lcd_wstrobe),
    .rs        (bus.addr[2]),
    .wdata     (bus.wdata[7:0]),
    .lcd_data  (lcd_data),
    .lcd_ctrl  (lcd_ctrl),
    .lcd_enable(lcd_enable),
    .busy      (lcd_busy)
  );

  audio_regs audio_reg_blk (
    .clk        (clk),
    .rst_n      (rst_n),
    .wstrobe    (audio_wstrobe),
    .wdata      (bus.wdata),
    .half_period(half_period),
    .tone_enable(tone_enable),
    .rdata      (audio_rdata),
    .restart    (restart)
  );

  audio_tone tone (
    .clk        (clk),
    .rst_n      (rst_n),
    .half_period(half_period),
    .tone_enable(tone_enable),
    .restart    (restart),
    .audio_out  (audio_out)
  );

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

//--- sim/periph_tb.sv
`timescale 1ns/100ps

module periph_tb;

  localparam int LCD_PULSE_CYCLES = 4;

  typedef enum logic [2:0] {
    OP_WRITE,
    OP_READ,
    OP_LCD,
    OP_AUDIO,
    OP_JOYPAD,
    OP_NOISE
  } op_e;

  typedef struct packed {
    op_e                  op;
    periph_pkg::word_t    addr;
    periph_pkg::word_t    wdata;
    periph_pkg::byte_en_t wenable;
    periph_pkg::word_t    exp_value;
  } entry_t;

  logic                 clk;
  logic                 rst_n;
  periph_pkg::bus_req_t bus;
  periph_pkg::word_t    rdata;
  logic [4:0]           joypad;
  logic [7:0]           lcd_data;
  logic [1:0]           lcd_ctrl;
  logic                 lcd_enable;
  logic                 audio_out;

  entry_t            stim_q[$];
  periph_pkg::word_t ram_model [4096];
  int                seed = 32'h6554_2f24;
  int                cycle_count = 0;
  int                cycle_limit = 0;
  int                pass_count = 0;
  int                fail_count = 0;
  bit                entry_failed;

  tb_clock_gen clock_gen (
    .clk  (clk),
    .rst_n(rst_n)
  );

  periph_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus       (bus),
    .rdata     (rdata),
    .joypad    (joypad),
    .lcd_data  (lcd_data),
    .lcd_ctrl  (lcd_ctrl),
    .lcd_enable(lcd_enable),
    .audio_out (audio_out)
  );

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input periph_pkg::word_t exp_value,
                                 input periph_pkg::word_t actual);
    $display("[FAIL] %s expected 0x%08h, got 0x%08h", name, exp_value, actual);
    entry_failed = 1'b1;
  endtask

  task automatic report_problem(input string msg);
    $display("%s", msg);
    entry_failed = 1'b1;
  endtask

  // Old word with the enabled bytes taken from the new one
  function automatic periph_pkg::word_t merge_bytes(input periph_pkg::word_t old_word,
                                                    input periph_pkg::word_t new_word,
                                                    input periph_pkg::byte_en_t be);
    periph_pkg::word_t result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        result[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return result;
  endfunction

  task automatic add_entry(input op_e op, input periph_pkg::word_t addr,
                           input periph_pkg::word_t wdata, input periph_pkg::byte_en_t be,
                           input periph_pkg::word_t exp_value);
    stim_q.push_back('{op, addr, wdata, be, exp_value});
  endtask

  task automatic add_ram_write(input periph_pkg::word_t addr, input periph_pkg::byte_en_t be);
    periph_pkg::word_t data;
    data = $random(seed);
    ram_model[addr[13:2]] = merge_bytes(ram_model[addr[13:2]], data, be);
    add_entry(OP_WRITE, addr, data, be, '0);
  endtask

  task automatic add_ram_read(input periph_pkg::word_t addr);
    add_entry(OP_READ, addr, '0, '0, ram_model[addr[13:2]]);
  endtask

  task automatic build_table();
    periph_pkg::word_t joy;
    // Full words first, 0x1000_0020 aliases word 8
    add_ram_write(32'h0000_0010, 4'hF);
    add_ram_write(32'h0000_3FFC, 4'hF);
    add_ram_write(32'h1000_0020, 4'hF);
    add_ram_read(32'h0000_0010);
    add_ram_write(32'h0000_0010, 4'b0101);
    add_ram_write(32'h0000_3FFC, 4'b1000);
    add_ram_read(32'h0000_0010);
    add_ram_read(32'h0000_3FFC);
    add_ram_read(32'h0000_0020);
    // Spare and video regions share RAM word offsets but must not write
    add_entry(OP_WRITE, 32'h4000_0010, 32'hDEAD_BEEF, 4'hF, '0);
    add_entry(OP_WRITE, 32'h9000_0010, 32'hCAFE_F00D, 4'hF, '0);
    add_entry(OP_WRITE, 32'hA000_3FFC, 32'h1234_5678, 4'hF, '0);
    add_ram_read(32'h0000_0010);
    add_ram_read(32'h0000_3FFC);
    add_entry(OP_READ, 32'h4000_0010, '0, '0, '0);
    add_entry(OP_READ, 32'h5000_0000, '0, '0, '0);
    add_entry(OP_READ, 32'h8000_0000, '0, '0, '0);
    add_entry(OP_READ, 32'hB000_3FFC, '0, '0, '0);
    for (int i = 0; i < 3; i++) begin
      joy = $random(seed);
      add_entry(OP_JOYPAD, '0, {27'b0, joy[4:0]}, '0, '0);
      add_entry(OP_READ, 32'h6000_0000, '0, '0, {27'b0, joy[4:0]});
    end
    add_entry(OP_LCD, 32'hC000_0004, 32'h0000_0041, 4'b0001, 32'h0000_0041);
    add_entry(OP_LCD, 32'hD000_0000, 32'h0000_0038, 4'b0001, 32'h0000_0038);
    add_entry(OP_AUDIO, 32'hE000_0000, 32'h0001_0005, 4'hF, 32'h0001_0005);
    add_entry(OP_AUDIO, 32'hF000_0000, 32'h0001_000B, 4'hF, 32'h0001_000B);
    add_entry(OP_AUDIO, 32'hE000_0000, 32'h0000_0007, 4'hF, 32'h0000_0007);
    add_entry(OP_NOISE, 32'h2000_0000, '0, '0, '0);
  endtask

  task automatic run_read(input entry_t e);
    @(posedge clk);
    bus <= '{e.addr, 32'h0, 4'h0};
    @(posedge clk);
    @(negedge clk);
    if (rdata !== e.exp_value) report_mismatch("rdata", e.exp_value, rdata);
  endtask

  task automatic run_lcd(input entry_t e);
    int                high_cycles;
    bit                done;
    periph_pkg::word_t status;
    high_cycles = 0;
    done = 1'b0;
    status = {23'b0, 1'b1, e.exp_value[7:0]};
    @(posedge clk);
    bus <= '{e.addr, e.wdata, e.wenable};
    for (int n = 0; n < 32 && !done; n++) begin
      @(posedge clk);
      // Second write arrives while busy and has to be dropped
      if (n == 0) begin
        bus <= '{e.addr ^ 32'h4, ~e.wdata, e.wenable};
      end else if (n == 1) begin
        bus <= '{e.addr, 32'h0, 4'h0};
      end else begin
        bus <= '0;
      end
      @(negedge clk);
      if (n == 2 && rdata !== status) report_mismatch("rdata", status, rdata);
      if (lcd_enable) high_cycles++;
      else done = 1'b1;
    end
    if (!done) report_problem("lcd_enable never dropped after the LCD write");
    if (high_cycles != LCD_PULSE_CYCLES) begin
      report_mismatch("lcd_enable cycles", LCD_PULSE_CYCLES, high_cycles);
    end
    if (lcd_data !== e.exp_value[7:0]) report_mismatch("lcd_data", e.exp_value, 32'(lcd_data));
    if (lcd_ctrl !== {1'b0, e.addr[2]}) begin
      report_mismatch("lcd_ctrl", 32'({1'b0, e.addr[2]}), 32'(lcd_ctrl));
    end
  endtask

  task automatic time_level(input logic level, input int limit, output int cycles);
    cycles = 0;
    while (audio_out === level && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic run_audio(input entry_t e);
    int half;
    int low_cycles;
    int high_cycles;
    half = int'(e.wdata[15:0]) + 1;
    @(posedge clk);
    bus <= '{e.addr, e.wdata, e.wenable};
    @(posedge clk);
    bus <= '{e.addr, 32'h0, 4'h0};
    @(posedge clk);
    bus <= '0;
    @(negedge clk);
    if (rdata !== e.exp_value) report_mismatch("rdata", e.exp_value, rdata);
    if (e.wdata[16]) begin
      // First low phase follows the restart, then one full high and low phase
      time_level(1'b0, 2 * half, low_cycles);
      time_level(1'b1, 2 * half, high_cycles);
      time_level(1'b0, 2 * half, low_cycles);
      if (high_cycles >= 2 * half || low_cycles >= 2 * half) begin
        report_problem("audio_out stopped toggling while enabled");
      end
      if (high_cycles != half) report_mismatch("audio_out high cycles", half, high_cycles);
      if (low_cycles != half) report_mismatch("audio_out low cycles", half, low_cycles);
    end else begin
      for (int n = 0; n < 24; n++) begin
        @(negedge clk);
        if (audio_out !== 1'b0) begin
          report_mismatch("audio_out", 32'h0, 32'(audio_out));
          break;
        end
      end
    end
  endtask

  task automatic run_noise(input entry_t e);
    periph_pkg::word_t prev;
    @(posedge clk);
    bus <= '{e.addr, 32'h0, 4'h0};
    @(posedge clk);
    prev = '0;
    repeat (8) begin
      @(negedge clk);
      if (rdata === '0) report_problem("noise read returned zero");
      if (rdata === prev) begin
        report_problem($sformatf("two noise reads in a row both gave 0x%08h", prev));
      end
      prev = rdata;
    end
  endtask

  initial begin
    entry_t e;
    bus    = '0;
    joypad = '0;
    build_table();
    cycle_limit = stim_q.size() * 64;
    @(posedge rst_n);
    for (int i = 0; i < stim_q.size(); i++) begin
      e = stim_q[i];
      entry_failed = 1'b0;
      case (e.op)
        OP_WRITE: begin
          @(posedge clk);
          bus <= '{e.addr, e.wdata, e.wenable};
        end
        OP_JOYPAD: begin
          @(posedge clk);
          joypad <= e.wdata[4:0];
          bus    <= '0;
          repeat (2) @(posedge clk);
        end
        OP_READ:  run_read(e);
        OP_LCD:   run_lcd(e);
        OP_AUDIO: run_audio(e);
        default:  run_noise(e);
      endcase
      if (entry_failed) fail_count++;
      else pass_count++;
      $display("entry %0d %s addr 0x%08h: %s", i, e.op.name(), e.addr,
               entry_failed ? "fail" : "pass");
    end
    @(posedge clk);
    bus <= '0;
    $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- sources.f
common/periph_pkg.sv
source/periph_bus_decode.sv
source/word_ram.sv
source/noise_lfsr.sv
lcd/lcd_unit.sv
audio/audio_regs.sv
audio/audio_tone.sv
source/periph_top.sv
sim/tb_clock_gen.sv
sim/periph_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = periph_tb
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^All checks passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
